/* project.f */
+incdir+verif
logic/mdu_pkg.sv
logic/mdu_decode.sv
logic/mdu_mul_iter.sv
logic/mdu_div_iter.sv
logic/mdu_result.sv
logic/mdu_top.sv
verif/mdu_tb.sv

/* Makefile */
# Verilator flow for the multiply/divide coprocessor
# Override from the command line, e.g. make sim SEED=12345 LOG=run.log

TOP       ?= mdu_tb
SEED      ?=
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
FILELIST  ?= project.f

LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
SEED_ARG   := $(if $(SEED),-GSEED=$(SEED))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) $(SEED_ARG) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL, no pass line in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/mdu_tb_model.svh */
// --------------------
// Reference model for the coprocessor testbench, included inside the
// testbench module after the package import. Eight M-extension ops
// and the xorshift generator used for stimulus.
// --------------------
`ifndef MDU_TB_MODEL_SVH
`define MDU_TB_MODEL_SVH

// Next state of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Operand widened to 2*XLEN, sign or zero extended
function automatic logic [2*XLEN-1:0] widen(input logic [XLEN-1:0] v, input logic sgn);
    return {{XLEN{sgn & v[XLEN-1]}}, v};
endfunction

function automatic logic [XLEN-1:0] model_result(input mdu_op_e op, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0]      prod;
    logic                   ovf;
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic signed [XLEN-1:0] sq;
    logic signed [XLEN-1:0] sr;
    ovf = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);   // Most negative by -1
    sa  = a;
    sb  = b;
    sq  = '0;
    sr  = '0;
    // Truncating signed division, defined away from the corner cases
    if ((b != '0) && !ovf) begin
        sq = sa / sb;
        sr = sa % sb;
    end
    case (op)
        OP_MUL:    prod = widen(a, 1'b0) * widen(b, 1'b0);
        OP_MULH:   prod = widen(a, 1'b1) * widen(b, 1'b1);
        OP_MULHSU: prod = widen(a, 1'b1) * widen(b, 1'b0);
        OP_MULHU:  prod = widen(a, 1'b0) * widen(b, 1'b0);
        default:   prod = '0;
    endcase
    case (op)
        OP_MUL:  return prod[XLEN-1:0];
        OP_MULH, OP_MULHSU, OP_MULHU: return prod[2*XLEN-1:XLEN];
        OP_DIV:  return (b == '0) ? '1 : ovf ? a : sq;
        OP_DIVU: return (b == '0) ? '1 : a / b;
        OP_REM:  return (b == '0) ? a : ovf ? '0 : sr;
        default: return (b == '0) ? a : a % b;   // REMU
    endcase
endfunction

`endif

/* verif/mdu_tb.sv */
// --------------------
// Testbench for the APB multiply/divide coprocessor.
// Random and corner operations are checked against a reference model,
// followed by bus error, status and abort scenarios.
// --------------------
`timescale 1ns/10ps

module mdu_tb;
    import mdu_pkg::*;

    `include "mdu_tb_model.svh"

    parameter logic [31:0] SEED = 32'h71a15c3c;

    localparam int MAX_TESTS       = 300;
    localparam int CYCLES_PER_TEST = 45;    // Divide plus its four bus accesses
    localparam int TIMEOUT_CYCLES  = MAX_TESTS * CYCLES_PER_TEST + 500;
    localparam logic [4:0] ADDR_UNMAPPED = 5'h14;

    logic            g_clk = 1'b0;
    logic            rst;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [4:0]      paddr;
    logic [XLEN-1:0] pwdata;
    logic [XLEN-1:0] prdata;
    logic            pready;
    logic            pslverr;
    logic [31:0]     rng_state = SEED;
    int              cycle_count = 0;

    mdu_top i_dut (
        .g_clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    always #4 g_clk = ~g_clk;   // 8 ns period

    // --------------------
    // Failure handling
    // --------------------
    task automatic end_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d cycles, the DUT stopped responding",
                     TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    task automatic check_result(input string name, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_resp(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s pslverr expected %b actual %b", name, expected, actual);
            end_with_failure();
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic next_rand(output logic [XLEN-1:0] v);
        rng_state = xorshift32(rng_state);
        v         = rng_state;
    endtask

    // One in four operands is a corner value
    task automatic pick_operand(output logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        next_rand(r);
        if (r[1:0] == 2'd0) begin
            case (r[3:2])
                2'd0:    v = '0;
                2'd1:    v = {{(XLEN-1){1'b0}}, 1'b1};
                2'd2:    v = '1;
                default: v = {1'b1, {(XLEN-1){1'b0}}};   // Most negative
            endcase
        end else begin
            next_rand(v);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic bus_transfer(input logic wr, input logic [4:0] addr,
                                input logic [XLEN-1:0] wdata,
                                output logic [XLEN-1:0] rdata, output logic err);
        logic ready;
        ready   = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge g_clk);
        #1;
        penable = 1'b1;
        while (!ready) begin
            @(negedge g_clk);   // Outputs settled mid-cycle
            ready = pready;
            rdata = prdata;
            err   = pslverr;
            @(posedge g_clk);
        end
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [XLEN-1:0] data,
                             output logic err);
        logic [XLEN-1:0] unused_rd;
        bus_transfer(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [XLEN-1:0] data,
                            output logic err);
        bus_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic start_op(input mdu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input string name);
        logic err;
        apb_write(ADDR_OPA, a, err);
        check_resp($sformatf("%s OPA write", name), 1'b0, err);
        apb_write(ADDR_OPB, b, err);
        check_resp($sformatf("%s OPB write", name), 1'b0, err);
        apb_write(ADDR_CTRL, {{(XLEN-3){1'b0}}, op}, err);
        check_resp($sformatf("%s CTRL write", name), 1'b0, err);
    endtask

    task automatic read_result(input string name, output logic [XLEN-1:0] rd);
        logic err;
        apb_read(ADDR_RESULT, rd, err);
        check_resp($sformatf("%s RESULT read", name), 1'b0, err);
    endtask

    task automatic run_op(input mdu_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input string name);
        logic [XLEN-1:0] rd;
        start_op(op, a, b, name);
        read_result(name, rd);
        check_result(name, model_result(op, a, b), rd);
    endtask

    task automatic check_status(input string name, input logic [XLEN-1:0] expected);
        logic [XLEN-1:0] rd;
        logic            err;
        apb_read(ADDR_STATUS, rd, err);
        check_resp(name, 1'b0, err);
        check_result(name, expected, rd);
    endtask

    task automatic send_abort(input string name);
        logic err;
        apb_write(ADDR_CTRL, XLEN'(1) << CTRL_ABORT_BIT, err);
        check_resp(name, 1'b0, err);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] rd;
        logic            err;
        mdu_op_e         op;

        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (2) @(posedge g_clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 100; i++) begin
            next_rand(r);
            op = mdu_op_e'({1'b0, r[1:0]});   // MUL .. MULHU
            pick_operand(a);
            pick_operand(b);
            run_op(op, a, b, $sformatf("%s #%0d", op.name(), i));
        end

        for (int i = 0; i < 100; i++) begin
            next_rand(r);
            op = mdu_op_e'({1'b1, r[1:0]});   // DIV .. REMU
            pick_operand(a);
            pick_operand(b);
            run_op(op, a, b, $sformatf("%s #%0d", op.name(), i));
        end

        // Divide by zero, all four flavours
        for (int i = 4; i < 8; i++) begin
            op = mdu_op_e'(i);
            next_rand(a);
            start_op(op, a, '0, $sformatf("%s by zero", op.name()));
            read_result($sformatf("%s by zero", op.name()), rd);
            check_result($sformatf("%s by zero", op.name()), (i >= 6) ? a : '1, rd);
        end

        // Signed overflow
        a = {1'b1, {(XLEN-1){1'b0}}};
        start_op(OP_DIV, a, '1, "DIV overflow");
        read_result("DIV overflow", rd);
        check_result("DIV overflow", a, rd);
        start_op(OP_REM, a, '1, "REM overflow");
        read_result("REM overflow", rd);
        check_result("REM overflow", '0, rd);

        // Bus errors while a divide runs
        next_rand(a);
        next_rand(b);
        b = b | 1;
        start_op(OP_DIV, a, b, "busy DIV");
        apb_write(ADDR_OPA, ~a, err);
        check_resp("OPA write while busy", 1'b1, err);
        apb_write(ADDR_OPB, ~b, err);
        check_resp("OPB write while busy", 1'b1, err);
        apb_write(ADDR_CTRL, {{(XLEN-3){1'b0}}, OP_MUL}, err);
        check_resp("CTRL write while busy", 1'b1, err);
        apb_read(ADDR_UNMAPPED, rd, err);
        check_resp("unmapped read", 1'b1, err);
        apb_write(ADDR_UNMAPPED, a, err);
        check_resp("unmapped write", 1'b1, err);
        read_result("busy DIV", rd);
        check_result("result after bus errors", model_result(OP_DIV, a, b), rd);
        apb_read(ADDR_OPA, rd, err);
        check_result("OPA kept after blocked write", a, rd);

        // Status and abort
        next_rand(a);
        next_rand(b);
        start_op(OP_DIVU, a, b, "status DIVU");
        check_status("STATUS busy after start", 32'h1);
        read_result("status DIVU", rd);
        check_result("status DIVU", model_result(OP_DIVU, a, b), rd);
        check_status("STATUS done after read", 32'h2);
        send_abort("abort when done");
        check_status("STATUS after abort when done", 32'h0);
        start_op(OP_DIV, a, b, "aborted DIV");
        check_status("STATUS busy before abort", 32'h1);
        send_abort("abort while busy");
        check_status("STATUS after abort while busy", 32'h0);
        pick_operand(a);
        pick_operand(b);
        run_op(OP_MULHSU, a, b, "MULHSU after abort");
        run_op(OP_REM, a, b, "REM after abort");

        $display("sim passed");
        $finish;
    end

endmodule

/* logic/mdu_top.sv */
// --------------------
// Top level of the APB multiply/divide coprocessor.
// Connects the bus decoder, both execute units and the result stage.
// --------------------
`timescale 1ns/10ps

module mdu_top (
    input  logic                     g_clk,
    input  logic                     rst,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [4:0]               paddr,
    input  logic [mdu_pkg::XLEN-1:0] pwdata,
    output logic [mdu_pkg::XLEN-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr
);
    import mdu_pkg::*;

    mdu_req_t          req;
    logic              start;
    logic              flush;
    logic              mul_valid;
    logic [2*XLEN-1:0] product;
    logic              div_valid;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;
    logic              done;
    logic [XLEN-1:0]   result;

    mdu_decode i_decode (
        .g_clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .done, .result, .prdata, .pready, .pslverr, .start, .flush, .req
    );

    // Both units see every start and pick by req.is_div
    mdu_mul_iter i_mul (
        .g_clk, .rst, .flush, .start, .req, .mul_valid, .product
    );

    mdu_div_iter i_div (
        .g_clk, .rst, .flush, .start, .req, .div_valid, .quotient, .remainder
    );

    mdu_result i_result (
        .g_clk, .rst, .flush, .start, .req, .mul_valid, .product,
        .div_valid, .quotient, .remainder, .done, .result
    );

endmodule

/* logic/mdu_result.sv */
// --------------------
// Result stage. Picks the product half or the quotient/remainder,
// restores the RISC-V sign rules and registers the value with done.
// --------------------
`timescale 1ns/10ps

module mdu_result (
    input  logic                       g_clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       start,
    input  mdu_pkg::mdu_req_t          req,
    input  logic                       mul_valid,
    input  logic [2*mdu_pkg::XLEN-1:0] product,
    input  logic                       div_valid,
    input  logic [mdu_pkg::XLEN-1:0]   quotient,
    input  logic [mdu_pkg::XLEN-1:0]   remainder,
    output logic                       done,
    output logic [mdu_pkg::XLEN-1:0]   result
);
    import mdu_pkg::*;

    logic            lhs_neg;
    logic            rhs_neg;
    logic            q_neg;
    logic [XLEN-1:0] mul_sel;
    logic [XLEN-1:0] div_sel;

    assign lhs_neg = req.lhs_signed && req.opa[XLEN-1];
    assign rhs_neg = req.rhs_signed && req.opb[XLEN-1];

    // Divide by zero keeps the all-ones quotient unsigned
    assign q_neg = (lhs_neg != rhs_neg) && (|req.opb);

    assign mul_sel = req.hi ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

    always_comb begin
        if (req.is_rem) begin
            div_sel = lhs_neg ? -remainder : remainder;   // Follows dividend sign
        end else begin
            div_sel = q_neg ? -quotient : quotient;
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge g_clk) begin
        if (rst) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            if (flush || start) begin
                done <= 1'b0;
            end else if (mul_valid || div_valid) begin
                done <= 1'b1;
            end
            if (mul_valid) begin
                result <= mul_sel;
            end else if (div_valid) begin
                result <= div_sel;
            end
        end
    end

endmodule

/* logic/mdu_div_iter.sv */
// --------------------
// Iterative restoring divider on operand magnitudes.
// One quotient bit per cycle, XLEN steps; div_valid is a registered
// pulse with the unsigned quotient and remainder alongside.
// --------------------
`timescale 1ns/10ps

module mdu_div_iter (
    input  logic                     g_clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     start,
    input  mdu_pkg::mdu_req_t        req,
    output logic                     div_valid,
    output logic [mdu_pkg::XLEN-1:0] quotient,
    output logic [mdu_pkg::XLEN-1:0] remainder
);
    import mdu_pkg::*;

    logic                    running;
    logic [$clog2(XLEN)-1:0] bit_idx;   // Quotient bit being resolved
    logic [2*XLEN-1:0]       divisor;   // Shifted divisor magnitude
    logic [XLEN-1:0]         rem_q;     // Partial remainder
    logic [XLEN-1:0]         quot_q;
    logic [XLEN-1:0]         opa_mag;
    logic [XLEN-1:0]         opb_mag;
    logic                    fits;
    logic                    last_step;
    logic                    go;

    assign go        = start && req.is_div;
    assign last_step = running && (bit_idx == '0);

    // Magnitudes; the most negative value maps onto itself as unsigned
    assign opa_mag = (req.lhs_signed && req.opa[XLEN-1]) ? -req.opa : req.opa;
    assign opb_mag = (req.rhs_signed && req.opb[XLEN-1]) ? -req.opb : req.opb;

    // Zero divisor always fits, so the quotient fills with ones
    assign fits = divisor <= {{XLEN{1'b0}}, rem_q};

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            running   <= 1'b0;
            bit_idx   <= '0;
            div_valid <= 1'b0;
        end else begin
            div_valid <= last_step;
            if (go) begin
                running <= 1'b1;
                bit_idx <= '1;          // XLEN-1, MSB first
            end else if (running) begin
                running <= !last_step;
                bit_idx <= bit_idx - 1'b1;
            end
        end
    end

    // Compare and subtract
    always_ff @(posedge g_clk) begin
        if (go) begin
            rem_q   <= opa_mag;
            divisor <= {{XLEN{1'b0}}, opb_mag} << (XLEN - 1);
            quot_q  <= '0;
        end else if (running) begin
            divisor <= divisor >> 1;
            quot_q  <= {quot_q[XLEN-2:0], fits};
            if (fits) begin
                rem_q <= rem_q - divisor[XLEN-1:0];
            end
        end
    end

    assign quotient  = quot_q;
    assign remainder = rem_q;

    a_no_restart : assert property (@(posedge g_clk) disable iff (rst)
        go |-> !running);

endmodule

/* logic/mdu_mul_iter.sv */
// --------------------
// Iterative shift-add multiplier, MUL_UNROLL multiplier bits per cycle.
// Produces the full 2*XLEN product; mul_valid and product are
// combinational in the last step cycle.
// --------------------
`timescale 1ns/10ps

module mdu_mul_iter (
    input  logic                       g_clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       start,
    input  mdu_pkg::mdu_req_t          req,
    output logic                       mul_valid,
    output logic [2*mdu_pkg::XLEN-1:0] product
);
    import mdu_pkg::*;

    logic                         running;
    logic [$clog2(MUL_STEPS)-1:0] step;
    logic [XLEN-1:0]              mplier;   // Unretired multiplier bits
    logic [2*XLEN-1:0]            acc;
    logic [2*XLEN-1:0]            n_acc;
    logic                         last_step;
    logic                         go;

    assign go        = start && !req.is_div;
    assign last_step = running && (step == MUL_STEPS - 1);

    // --------------------
    // One unrolled step
    // --------------------
    // The upper half plus one sign bit is added to, then the whole
    // accumulator shifts right one place per multiplier bit
    always_comb begin : mul_step
        logic [XLEN:0] add_l;
        logic [XLEN:0] add_r;
        logic [XLEN:0] sum;
        logic          do_sub;
        n_acc = acc;
        for (int i = 0; i < MUL_UNROLL; i++) begin
            // Signed multiplier MSB carries negative weight
            do_sub = last_step && (i == MUL_UNROLL - 1) && req.rhs_signed;
            add_l  = {req.lhs_signed & n_acc[2*XLEN-1], n_acc[2*XLEN-1:XLEN]};
            add_r  = mplier[i] ? {req.lhs_signed & req.opa[XLEN-1], req.opa} : '0;
            if (do_sub) begin
                add_r = ~add_r;
            end
            sum    = add_l + add_r + {{XLEN{1'b0}}, do_sub};
            n_acc  = {sum, n_acc[XLEN-1:1]};
        end
    end

    always_ff @(posedge g_clk) begin
        if (rst || flush) begin
            running <= 1'b0;
            step    <= '0;
        end else if (go) begin
            running <= 1'b1;
            step    <= '0;
        end else if (running) begin
            running <= !last_step;
            step    <= step + 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (go) begin
            acc    <= '0;
            mplier <= req.opb;
        end else if (running) begin
            acc    <= n_acc;
            mplier <= mplier >> MUL_UNROLL;
        end
    end

    assign mul_valid = last_step;
    assign product   = n_acc;     // Final value in the valid cycle

    a_valid_pulse : assert property (@(posedge g_clk) disable iff (rst)
        mul_valid |=> !mul_valid);

endmodule

/* logic/mdu_decode.sv */
// --------------------
// APB slave front end of the coprocessor.
// Holds the operand registers, turns a CTRL write into a request plus
// a start or flush pulse, tracks busy and stalls RESULT reads.
// --------------------
`timescale 1ns/10ps

module mdu_decode (
    input  logic                     g_clk,
    input  logic                     rst,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [4:0]               paddr,
    input  logic [mdu_pkg::XLEN-1:0] pwdata,
    input  logic                     done,
    input  logic [mdu_pkg::XLEN-1:0] result,
    output logic [mdu_pkg::XLEN-1:0] prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     start,
    output logic                     flush,
    output mdu_pkg::mdu_req_t        req
);
    import mdu_pkg::*;

    logic [XLEN-1:0] opa_q;
    logic [XLEN-1:0] opb_q;
    mdu_op_e         op_q;      // Last opcode, read back on CTRL
    mdu_req_t        dec_req;
    logic            busy_q;
    logic            busy;
    logic            active;
    logic            access;
    logic            abort;
    logic            addr_hit;
    logic            ro_addr;
    logic            wr_blocked;
    logic            wr_err;
    logic            wr_ok;

    // --------------------
    // Bus decode
    // --------------------
    assign access = psel && penable;
    assign abort  = pwdata[CTRL_ABORT_BIT];
    assign busy   = busy_q && !done;    // Drops in the cycle done rises
    assign active = busy || start;

    assign addr_hit = (paddr == ADDR_OPA) || (paddr == ADDR_OPB) || (paddr == ADDR_CTRL) ||
                      (paddr == ADDR_STATUS) || (paddr == ADDR_RESULT);
    assign ro_addr  = (paddr == ADDR_STATUS) || (paddr == ADDR_RESULT);

    // Abort is the one CTRL write a running operation accepts
    assign wr_blocked = active && ((paddr == ADDR_OPA) || (paddr == ADDR_OPB) ||
                                   ((paddr == ADDR_CTRL) && !abort));
    assign wr_err     = pwrite && (ro_addr || wr_blocked);

    assign pslverr = access && (!addr_hit || wr_err);
    assign pready  = !(access && !pwrite && (paddr == ADDR_RESULT) && busy);
    assign wr_ok   = access && pwrite && addr_hit && !wr_err;

    // Opcode into request flags
    always_comb begin
        dec_req     = '0;
        dec_req.opa = opa_q;
        dec_req.opb = opb_q;
        case (mdu_op_e'(pwdata[2:0]))
            OP_MUL:    dec_req.hi = 1'b0;
            OP_MULH:   {dec_req.hi, dec_req.lhs_signed, dec_req.rhs_signed} = 3'b111;
            OP_MULHSU: {dec_req.hi, dec_req.lhs_signed} = 2'b11;
            OP_MULHU:  dec_req.hi = 1'b1;
            OP_DIV:    {dec_req.is_div, dec_req.lhs_signed, dec_req.rhs_signed} = 3'b111;
            OP_DIVU:   dec_req.is_div = 1'b1;
            OP_REM: begin
                {dec_req.is_div, dec_req.lhs_signed, dec_req.rhs_signed} = 3'b111;
                dec_req.is_rem = 1'b1;
            end
            default:   {dec_req.is_div, dec_req.is_rem} = 2'b11;   // REMU
        endcase
    end

    // --------------------
    // Control state
    // --------------------
    always_ff @(posedge g_clk) begin
        if (rst) begin
            start  <= 1'b0;
            flush  <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            start <= wr_ok && (paddr == ADDR_CTRL) && !abort;
            flush <= wr_ok && (paddr == ADDR_CTRL) && abort;
            if (flush) begin
                busy_q <= 1'b0;
            end else if (start) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Operands and request
    always_ff @(posedge g_clk) begin
        if (wr_ok && (paddr == ADDR_OPA)) opa_q <= pwdata;
        if (wr_ok && (paddr == ADDR_OPB)) opb_q <= pwdata;
        if (wr_ok && (paddr == ADDR_CTRL) && !abort) begin
            req  <= dec_req;
            op_q <= mdu_op_e'(pwdata[2:0]);
        end
    end

    // Read mux
    always_comb begin
        case (paddr)
            ADDR_OPA:    prdata = opa_q;
            ADDR_OPB:    prdata = opb_q;
            ADDR_CTRL:   prdata = {{(XLEN-3){1'b0}}, op_q};
            ADDR_STATUS: prdata = {{(XLEN-2){1'b0}}, done, busy};
            ADDR_RESULT: prdata = result;
            default:     prdata = '0;
        endcase
    end

    // A second start could only come from a CTRL write slipping past busy
    a_no_start_busy : assert property (@(posedge g_clk) disable iff (rst)
        start |-> !busy_q);

endmodule

/* logic/mdu_pkg.sv */
// --------------------
// Shared definitions for the APB multiply/divide coprocessor.
// Widths, opcodes, register map and the decoded request struct.
// Modules import it with a wildcard inside their body.
// --------------------
package mdu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN       = 32;
    localparam int MUL_UNROLL = 4;                  // Multiplier bits per cycle
    localparam int MUL_STEPS  = XLEN / MUL_UNROLL;  // Multiplier iterations

    // --------------------
    // APB register map
    // --------------------
    localparam logic [4:0] ADDR_OPA    = 5'h00;   // First operand
    localparam logic [4:0] ADDR_OPB    = 5'h04;   // Second operand
    localparam logic [4:0] ADDR_CTRL   = 5'h08;   // Opcode, abort
    localparam logic [4:0] ADDR_STATUS = 5'h0C;   // Bit 0 busy, bit 1 done
    localparam logic [4:0] ADDR_RESULT = 5'h10;   // Stalls while busy

    // Writing 1 here flushes the unit instead of starting it
    localparam int CTRL_ABORT_BIT = 8;

    // Opcode in CTRL[2:0], same order as the M extension funct3
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } mdu_op_e;

    // --------------------
    // Decoded request
    // --------------------
    // Held stable by the decoder from one start to the next, so the
    // execute units and the result stage may read it at any time
    typedef struct packed {
        logic            is_div;      // Divide or remainder
        logic            hi;          // Upper product half
        logic            lhs_signed;  // opa is signed
        logic            rhs_signed;  // opb is signed
        logic            is_rem;      // Remainder, not quotient
        logic [XLEN-1:0] opa;
        logic [XLEN-1:0] opb;
    } mdu_req_t;

endpackage
